//--- hw/pss_settings.svh
`ifndef PSS_SETTINGS_SVH
`define PSS_SETTINGS_SVH

// local sequence length in samples
`define PSS_LEN 16

// signed width of each I and Q component
`define SAMPLE_W 8

// per component correlation sum, 16 taps of 8 bit samples
`define SUM_W 13

// re_sum^2 + im_sum^2
`define CORR_W 26

// peak detector history
`define WINDOW_LEN 8
`define WINDOW_LOG2 3

`define COUNT_W 16

// detection shift, 0 to 7
`define SHIFT_W 3

`endif

//--- hw/pss_pkg.sv
`default_nettype none

`include "pss_settings.svh"

package pss_pkg;

    // complex baseband sample
    typedef struct packed {
        logic signed [`SAMPLE_W-1:0] re;
        logic signed [`SAMPLE_W-1:0] im;
    } sample_t;

    // correlation power
    typedef logic [`CORR_W-1:0] corr_t;

    typedef logic [1:0] nid_t;

    typedef enum logic [1:0] {
        MODE_SEARCH = 2'd0,
        MODE_FIND   = 2'd1,
        MODE_PAUSE  = 2'd2
    } mode_t;

    // ---------------------------------------------------------------------------
    // local sequences, one per N_id_2
    // cyclic shifts by 0, 5 and 10 of a 15 chip m-sequence plus one chip
    // set bit means a tap of +1
    // tap 0 lines up with the oldest sample in the window
    // ---------------------------------------------------------------------------
    localparam logic [`PSS_LEN-1:0] PSS_TAPS [3] = '{
        16'hFAC8,
        16'hA3D6,
        16'hD91E
    };

endpackage

`default_nettype wire

//--- hw/sample_history.sv
`timescale 1ns/1ps
`default_nettype none

module sample_history #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 2
) (
    input  wire   clk_i,
    input  wire   reset_ni,
    input  wire   push_i,
    input  wire   item_t item_i,
    output item_t window_o [DEPTH]
);

    item_t items_q [DEPTH];

    // oldest item at index 0, newest at DEPTH-1
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int i = 0; i < DEPTH; i++) begin
                items_q[i] <= '0;
            end
        end else if (push_i) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                items_q[i] <= items_q[i + 1];
            end
            items_q[DEPTH - 1] <= item_i;
        end
    end

    assign window_o = items_q;

endmodule

`default_nettype wire

//--- hw/pss_correlator.sv
`timescale 1ns/1ps
`default_nettype none

`include "pss_settings.svh"

module pss_correlator #(
    parameter logic [`PSS_LEN-1:0] TAPS = pss_pkg::PSS_TAPS[0]
) (
    input  wire                   clk_i,
    input  wire                   reset_ni,
    input  wire pss_pkg::sample_t sample_i,
    input  wire                   sample_valid_i,
    output pss_pkg::corr_t        corr_o,
    output logic                  corr_valid_o
);

    typedef logic signed [`SUM_W-1:0]  sum_t;
    typedef logic signed [`CORR_W-1:0] wide_t;

    pss_pkg::sample_t history [`PSS_LEN-1];
    pss_pkg::sample_t window [`PSS_LEN];
    sum_t             re_sum_d;
    sum_t             im_sum_d;
    sum_t             re_sum_q;
    sum_t             im_sum_q;
    logic             sum_valid_q;
    wide_t            re_sq;
    wide_t            im_sq;

    // previous 15 samples, the incoming one completes the window
    sample_history #(
        .item_t (pss_pkg::sample_t),
        .DEPTH  (`PSS_LEN - 1)
    ) history_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .push_i   (sample_valid_i),
        .item_i   (sample_i),
        .window_o (history)
    );

    always_comb begin
        for (int k = 0; k < `PSS_LEN - 1; k++) begin
            window[k] = history[k];
        end
        window[`PSS_LEN - 1] = sample_i;
    end

    // +-1 taps, so add or subtract only
    always_comb begin
        re_sum_d = '0;
        im_sum_d = '0;
        for (int k = 0; k < `PSS_LEN; k++) begin
            if (TAPS[k]) begin
                re_sum_d = re_sum_d + sum_t'(window[k].re);
                im_sum_d = im_sum_d + sum_t'(window[k].im);
            end else begin
                re_sum_d = re_sum_d - sum_t'(window[k].re);
                im_sum_d = im_sum_d - sum_t'(window[k].im);
            end
        end
    end

    // ---------------------------------------------------------------------------
    // stage 1 sums, stage 2 power
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sum_valid_q  <= 1'b0;
            corr_valid_o <= 1'b0;
        end else begin
            sum_valid_q  <= sample_valid_i;
            corr_valid_o <= sum_valid_q;
        end
    end

    assign re_sq = wide_t'(re_sum_q) * wide_t'(re_sum_q);
    assign im_sq = wide_t'(im_sum_q) * wide_t'(im_sum_q);

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            re_sum_q <= re_sum_d;
            im_sum_q <= im_sum_d;
        end
        if (sum_valid_q) begin
            corr_o <= pss_pkg::corr_t'(re_sq + im_sq);
        end
    end

endmodule

`default_nettype wire

//--- hw/peak_detector.sv
`timescale 1ns/1ps
`default_nettype none

`include "pss_settings.svh"

module peak_detector (
    input  wire                 clk_i,
    input  wire                 reset_ni,
    input  wire pss_pkg::corr_t corr_i,
    input  wire                 corr_valid_i,
    input  wire pss_pkg::corr_t noise_limit_i,
    input  wire [`SHIFT_W-1:0]  detection_shift_i,
    output logic                peak_o
);

    localparam int ACC_W    = `CORR_W + `WINDOW_LOG2;
    // room for the largest shift, so the threshold never wraps
    localparam int THRESH_W = `CORR_W + (1 << `SHIFT_W) - 1;

    typedef logic [ACC_W-1:0]    acc_t;
    typedef logic [THRESH_W-1:0] thresh_t;

    pss_pkg::corr_t history [`WINDOW_LEN];
    acc_t           history_sum;
    pss_pkg::corr_t history_avg;
    thresh_t        threshold;
    logic           above_noise;
    logic           above_avg;

    // previous correlation values, new one goes in after the compare
    sample_history #(
        .item_t (pss_pkg::corr_t),
        .DEPTH  (`WINDOW_LEN)
    ) history_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .push_i   (corr_valid_i),
        .item_i   (corr_i),
        .window_o (history)
    );

    always_comb begin
        history_sum = '0;
        for (int i = 0; i < `WINDOW_LEN; i++) begin
            history_sum = history_sum + acc_t'(history[i]);
        end
    end

    // mean of the window, scaled up by the detection shift
    assign history_avg = history_sum[ACC_W-1:`WINDOW_LOG2];
    assign threshold   = thresh_t'(history_avg) << detection_shift_i;

    assign above_noise = corr_i > noise_limit_i;
    assign above_avg   = thresh_t'(corr_i) > threshold;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            peak_o <= 1'b0;
        end else begin
            peak_o <= corr_valid_i && above_noise && above_avg;
        end
    end

endmodule

`default_nettype wire

//--- hw/pss_detector_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "pss_settings.svh"

module pss_detector_ctrl (
    input  wire                 clk_i,
    input  wire                 reset_ni,
    input  wire pss_pkg::mode_t mode_i,
    input  wire pss_pkg::nid_t  requested_nid_i,
    input  wire [2:0]           peaks_i,
    output logic                corr_enable_o,
    output pss_pkg::nid_t       nid_o,
    output logic                nid_valid_o,
    output logic [`COUNT_W-1:0] peak_count_0_o,
    output logic [`COUNT_W-1:0] peak_count_1_o,
    output logic [`COUNT_W-1:0] peak_count_2_o
);

    typedef logic [`COUNT_W-1:0] count_t;

    logic          single_peak;
    pss_pkg::nid_t peak_nid;
    logic          report;
    count_t        count_q [3];

    // only a lone peak is ever reported
    assign single_peak = $onehot(peaks_i);

    always_comb begin
        case (peaks_i)
            3'b001:  peak_nid = 2'd0;
            3'b010:  peak_nid = 2'd1;
            default: peak_nid = 2'd2;
        endcase
    end

    always_comb begin
        case (mode_i)
            pss_pkg::MODE_SEARCH: report = single_peak;
            pss_pkg::MODE_FIND:   report = single_peak && (peak_nid == requested_nid_i);
            default:              report = 1'b0;
        endcase
    end

    // ---------------------------------------------------------------------------
    // mode decode
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            corr_enable_o <= 1'b0;
            nid_valid_o   <= 1'b0;
        end else begin
            corr_enable_o <= (mode_i == pss_pkg::MODE_SEARCH) || (mode_i == pss_pkg::MODE_FIND);
            nid_valid_o   <= report;
        end
    end

    always_ff @(posedge clk_i) begin
        if (report) begin
            nid_o <= peak_nid;
        end
    end

    // peak counters run in every mode and wrap
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int k = 0; k < 3; k++) begin
                count_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < 3; k++) begin
                if (peaks_i[k]) begin
                    count_q[k] <= count_q[k] + count_t'(1);
                end
            end
        end
    end

    assign peak_count_0_o = count_q[0];
    assign peak_count_1_o = count_q[1];
    assign peak_count_2_o = count_q[2];

endmodule

`default_nettype wire

//--- hw/pss_detector.sv
`timescale 1ns/1ps
`default_nettype none

`include "pss_settings.svh"

module pss_detector (
    input  wire                   clk_i,
    input  wire                   reset_ni,

    // sample stream
    input  wire pss_pkg::sample_t sample_i,
    input  wire                   sample_valid_i,

    // configuration
    input  wire pss_pkg::mode_t   mode_i,
    input  wire pss_pkg::nid_t    requested_nid_i,
    input  wire pss_pkg::corr_t   noise_limit_i,
    input  wire [`SHIFT_W-1:0]    detection_shift_i,

    // result
    output pss_pkg::nid_t         nid_o,
    output logic                  nid_valid_o,
    output logic [`COUNT_W-1:0]   peak_count_0_o,
    output logic [`COUNT_W-1:0]   peak_count_1_o,
    output logic [`COUNT_W-1:0]   peak_count_2_o
);

    logic           corr_enable;
    logic           corr_sample_valid;
    pss_pkg::corr_t corr [3];
    logic [2:0]     corr_valid;
    logic [2:0]     peaks;

    // samples are dropped before the correlators while paused
    assign corr_sample_valid = sample_valid_i && corr_enable;

    // ---------------------------------------------------------------------------
    // one correlator and one peak detector per N_id_2
    // ---------------------------------------------------------------------------
    for (genvar g = 0; g < 3; g++) begin : gen_nid
        pss_correlator #(
            .TAPS (pss_pkg::PSS_TAPS[g])
        ) correlator_i (
            .clk_i          (clk_i),
            .reset_ni       (reset_ni),
            .sample_i       (sample_i),
            .sample_valid_i (corr_sample_valid),
            .corr_o         (corr[g]),
            .corr_valid_o   (corr_valid[g])
        );

        peak_detector peak_detector_i (
            .clk_i             (clk_i),
            .reset_ni          (reset_ni),
            .corr_i            (corr[g]),
            .corr_valid_i      (corr_valid[g]),
            .noise_limit_i     (noise_limit_i),
            .detection_shift_i (detection_shift_i),
            .peak_o            (peaks[g])
        );
    end

    pss_detector_ctrl ctrl_i (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .mode_i          (mode_i),
        .requested_nid_i (requested_nid_i),
        .peaks_i         (peaks),
        .corr_enable_o   (corr_enable),
        .nid_o           (nid_o),
        .nid_valid_o     (nid_valid_o),
        .peak_count_0_o  (peak_count_0_o),
        .peak_count_1_o  (peak_count_1_o),
        .peak_count_2_o  (peak_count_2_o)
    );

endmodule

`default_nettype wire

//--- testbench/pss_detector_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "pss_settings.svh"

module pss_detector_assertions (
    input wire                 clk_i,
    input wire                 reset_ni,
    input wire pss_pkg::mode_t mode_i,
    input wire pss_pkg::nid_t  nid_o,
    input wire                 nid_valid_o,
    input wire [`COUNT_W-1:0]  peak_count_0_o,
    input wire [`COUNT_W-1:0]  peak_count_1_o,
    input wire [`COUNT_W-1:0]  peak_count_2_o
);

    typedef logic [`COUNT_W-1:0] count_t;

    // report register is one stage behind the mode decode
    pause_quiet: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (mode_i == pss_pkg::MODE_PAUSE && $past(mode_i) == pss_pkg::MODE_PAUSE) |-> !nid_valid_o)
        else $error("nid_valid_o high during pause");

    // a report lands on the same edge as the step of its own peak counter
    nid_range: assert property (@(posedge clk_i) disable iff (!reset_ni)
        nid_valid_o |-> (nid_o == 2'd0 && peak_count_0_o != $past(peak_count_0_o))
            || (nid_o == 2'd1 && peak_count_1_o != $past(peak_count_1_o))
            || (nid_o == 2'd2 && peak_count_2_o != $past(peak_count_2_o)))
        else $error("nid_o out of range or reported without a matching peak");

    count_0_step: assert property (@(posedge clk_i) disable iff (!reset_ni)
        peak_count_0_o == $past(peak_count_0_o)
            || peak_count_0_o == $past(peak_count_0_o) + count_t'(1))
        else $error("peak_count_0_o jumped");

    count_1_step: assert property (@(posedge clk_i) disable iff (!reset_ni)
        peak_count_1_o == $past(peak_count_1_o)
            || peak_count_1_o == $past(peak_count_1_o) + count_t'(1))
        else $error("peak_count_1_o jumped");

    count_2_step: assert property (@(posedge clk_i) disable iff (!reset_ni)
        peak_count_2_o == $past(peak_count_2_o)
            || peak_count_2_o == $past(peak_count_2_o) + count_t'(1))
        else $error("peak_count_2_o jumped");

endmodule

bind pss_detector pss_detector_assertions assertions_i (.*);

`default_nettype wire

//--- testbench/pss_detector_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pss_settings.svh"

module pss_detector_tb;

    typedef logic [`COUNT_W-1:0]         count_t;
    typedef logic signed [`SAMPLE_W-1:0] comp_t;

    localparam int BURST_LEN  = 56;
    localparam int NUM_BURSTS = 18;
    localparam int NOISE_LEN  = 64;
    localparam int MARGIN     = 300;

    logic                clk_i;
    logic                reset_ni;
    pss_pkg::sample_t    sample_i;
    logic                sample_valid_i;
    pss_pkg::mode_t      mode_i;
    pss_pkg::nid_t       requested_nid_i;
    pss_pkg::corr_t      noise_limit_i;
    logic [`SHIFT_W-1:0] detection_shift_i;
    pss_pkg::nid_t       nid_o;
    logic                nid_valid_o;
    count_t              peak_count_0_o;
    count_t              peak_count_1_o;
    count_t              peak_count_2_o;

    // reference model state
    pss_pkg::sample_t model_window [`PSS_LEN];
    pss_pkg::corr_t   model_history [3][`WINDOW_LEN];
    count_t           model_count [3];
    pss_pkg::nid_t    expected_nids [$];
    pss_pkg::nid_t    seen_nids [$];

    int cycle = 0;
    int burst_end_cycle = 0;
    int last_valid_cycle = -1;
    int test_errors = 0;
    int errors = 0;
    int failed_tests = 0;

    pss_detector pss_detector_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle = cycle + 1;

    // reports, sampled away from the active edge
    always @(negedge clk_i) begin
        if (nid_valid_o === 1'b1) begin
            seen_nids.push_back(nid_o);
            last_valid_cycle = cycle;
        end
    end

    initial begin
        #((NUM_BURSTS * BURST_LEN + NOISE_LEN + MARGIN) * 4 * 2);
        $display("timeout: the run did not finish in time");
        $display("tests failed");
        $finish;
    end

    // ---------------------------------------------------------------------------
    // reference model
    // ---------------------------------------------------------------------------
    function automatic pss_pkg::corr_t model_power(input int nid);
        int re_sum = 0;
        int im_sum = 0;
        for (int k = 0; k < `PSS_LEN; k++) begin
            if (pss_pkg::PSS_TAPS[nid][k]) begin
                re_sum += model_window[k].re;
                im_sum += model_window[k].im;
            end else begin
                re_sum -= model_window[k].re;
                im_sum -= model_window[k].im;
            end
        end
        return pss_pkg::corr_t'(re_sum * re_sum + im_sum * im_sum);
    endfunction

    task automatic model_accept(input pss_pkg::sample_t s);
        pss_pkg::corr_t power;
        longint         limit;
        int             peak_total = 0;
        pss_pkg::nid_t  peak_nid = '0;
        for (int k = 0; k < `PSS_LEN - 1; k++) model_window[k] = model_window[k + 1];
        model_window[`PSS_LEN - 1] = s;
        for (int n = 0; n < 3; n++) begin
            power = model_power(n);
            limit = 0;
            for (int i = 0; i < `WINDOW_LEN; i++) limit += model_history[n][i];
            limit = (limit >> `WINDOW_LOG2) << detection_shift_i;
            if (power > noise_limit_i && longint'(power) > limit) begin
                peak_total++;
                peak_nid = pss_pkg::nid_t'(n);
                model_count[n] = model_count[n] + count_t'(1);
            end
            for (int i = 0; i < `WINDOW_LEN - 1; i++) model_history[n][i] = model_history[n][i + 1];
            model_history[n][`WINDOW_LEN - 1] = power;
        end
        if (peak_total == 1 && (mode_i == pss_pkg::MODE_SEARCH
                || (mode_i == pss_pkg::MODE_FIND && peak_nid == requested_nid_i))) begin
            expected_nids.push_back(peak_nid);
        end
    endtask

    // ---------------------------------------------------------------------------
    // stimulus
    // ---------------------------------------------------------------------------
    task automatic drive_sample(input pss_pkg::sample_t s);
        @(posedge clk_i);
        #1;
        sample_i       = s;
        sample_valid_i = 1'b1;
        if (mode_i != pss_pkg::MODE_PAUSE) model_accept(s);
    endtask

    task automatic drive_idle();
        @(posedge clk_i);
        #1;
        sample_valid_i = 1'b0;
    endtask

    // zeros, the local sequence of one N_id_2, zeros
    task automatic drive_burst(input int nid, input int amp);
        pss_pkg::sample_t s;
        for (int i = 0; i < 16; i++) drive_sample('0);
        for (int k = 0; k < `PSS_LEN; k++) begin
            s.re = pss_pkg::PSS_TAPS[nid][k] ? comp_t'(amp) : comp_t'(-amp);
            s.im = '0;
            drive_sample(s);
        end
        burst_end_cycle = cycle;
        for (int i = 0; i < BURST_LEN - 32; i++) drive_sample('0);
    endtask

    task automatic drive_noise(input int count);
        pss_pkg::sample_t s;
        for (int i = 0; i < count; i++) begin
            s.re = comp_t'(int'($urandom_range(6)) - 3);
            s.im = comp_t'(int'($urandom_range(6)) - 3);
            drive_sample(s);
        end
    endtask

    task automatic set_mode(input pss_pkg::mode_t mode);
        drive_idle();
        mode_i = mode;
        // corr_enable follows one cycle later
        repeat (2) drive_idle();
    endtask

    // ---------------------------------------------------------------------------
    // checks
    // ---------------------------------------------------------------------------
    task automatic check_nid(input string name, input pss_pkg::nid_t expected,
                             input pss_pkg::nid_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: nid expected %0d actual %0d", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input count_t expected, input count_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: peak count expected %0d actual %0d", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("mismatch %s: latency expected %0d actual %0d", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int waited = 0;
        drive_idle();
        while (seen_nids.size() < expected_nids.size() && waited < 16) begin
            drive_idle();
            waited++;
        end
        if (seen_nids.size() < expected_nids.size()) begin
            $display("%s: nid_valid_o pulse missing, %0d of %0d seen", name,
                     seen_nids.size(), expected_nids.size());
            test_errors++;
        end else if (seen_nids.size() > expected_nids.size()) begin
            $display("%s: nid_valid_o pulsed %0d times where %0d were expected", name,
                     seen_nids.size(), expected_nids.size());
            test_errors++;
        end
        for (int i = 0; i < seen_nids.size() && i < expected_nids.size(); i++) begin
            check_nid(name, expected_nids[i], seen_nids[i]);
        end
        check_count(name, model_count[0], peak_count_0_o);
        check_count(name, model_count[1], peak_count_1_o);
        check_count(name, model_count[2], peak_count_2_o);
        $display("test %s: %0d errors", name, test_errors);
        if (test_errors != 0) failed_tests++;
        errors += test_errors;
        test_errors = 0;
        expected_nids.delete();
        seen_nids.delete();
    endtask

    // ---------------------------------------------------------------------------
    // directed tests
    // ---------------------------------------------------------------------------
    task automatic test_search();
        set_mode(pss_pkg::MODE_SEARCH);
        for (int k = 0; k < 3; k++) drive_burst(k, 40);
        finish_test("search");
    endtask

    task automatic test_find();
        set_mode(pss_pkg::MODE_FIND);
        for (int k = 0; k < 3; k++) begin
            requested_nid_i = pss_pkg::nid_t'((k + 1) % 3);
            drive_burst(k, 40);
            requested_nid_i = pss_pkg::nid_t'(k);
            drive_burst(k, 40);
        end
        finish_test("find");
    endtask

    task automatic test_pause();
        set_mode(pss_pkg::MODE_PAUSE);
        for (int k = 0; k < 3; k++) drive_burst(k, 40);
        finish_test("pause");
    endtask

    task automatic test_thresholds();
        set_mode(pss_pkg::MODE_SEARCH);
        drive_noise(NOISE_LEN);
        detection_shift_i = 3'd7;
        drive_burst(0, 40);
        detection_shift_i = 3'd0;
        drive_burst(0, 40);
        detection_shift_i = 3'd1;
        finish_test("thresholds");
    endtask

    task automatic test_counters();
        drive_burst(2, 40);
        drive_burst(0, 40);
        drive_burst(2, 40);
        finish_test("counters");
    endtask

    task automatic test_latency();
        last_valid_cycle = -1;
        drive_burst(1, 40);
        check_latency("latency", 4, last_valid_cycle - burst_end_cycle);
        finish_test("latency");
    endtask

    initial begin
        void'($urandom(32'h94b9));
        reset_ni          = 1'b0;
        sample_i          = '0;
        sample_valid_i    = 1'b0;
        mode_i            = pss_pkg::MODE_SEARCH;
        requested_nid_i   = '0;
        noise_limit_i     = pss_pkg::corr_t'(250000);
        detection_shift_i = 3'd1;
        model_window      = '{default: '0};
        model_history     = '{default: '0};
        model_count       = '{default: '0};
        repeat (8) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;
        test_search();
        test_find();
        test_pause();
        test_thresholds();
        test_counters();
        test_latency();
        $display("6 tests, %0d failed, %0d errors", failed_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
hw/pss_pkg.sv
hw/sample_history.sv
hw/pss_correlator.sv
hw/peak_detector.sv
hw/pss_detector_ctrl.sv
hw/pss_detector.sv
testbench/pss_detector_assertions.sv
testbench/pss_detector_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the PSS detector testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pss_detector_tb -f all.f

output=$(./obj_dir/Vpss_detector_tb)
echo "$output"

# the run passes only if the testbench printed its pass message
echo "$output" | grep -q "all tests passed"
